/* src/drp_pkg.sv */
package drp_pkg;

  // ==========================================================================
  // dynamic reconfiguration port of the clock synthesizer
  // ==========================================================================

  localparam int ADDR_W = 7;
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] drp_addr_t;
  typedef logic [DATA_W-1:0] drp_data_t;

  // one access where en is high for a single cycle
  typedef struct packed {
    logic      en;
    logic      we;    // 0 for a read
    drp_addr_t addr;
    drp_data_t di;
  } drp_req_t;

  typedef struct packed {
    logic      rdy;   // closes the access started by en
    drp_data_t dout;
  } drp_rsp_t;

  // read-modify-write of one register
  // a set mask bit keeps the bit already in the register
  typedef struct packed {
    drp_addr_t addr;
    drp_data_t mask;
    drp_data_t data;
  } drp_step_t;

endpackage

/* src/clock_cfg_pkg.sv */
package clock_cfg_pkg;

  // ==========================================================================
  // frequency settings and the register steps that select them
  // ==========================================================================

  localparam int STEPS = 4;  // registers touched per setting

  typedef logic [1:0] freq_idx_t;
  localparam freq_idx_t FREQ_RESERVED = 2'd3;

  typedef drp_pkg::drp_step_t [STEPS-1:0] cfg_seq_t;

  // high and low counts of output 0 and of the feedback divider
  typedef struct packed {
    logic [5:0] out0_high;
    logic [5:0] out0_low;
    logic [5:0] fb_high;
    logic [5:0] fb_low;
  } mmcm_setting_t;

  localparam drp_pkg::drp_addr_t REG_CLKOUT0_1 = 7'h08;
  localparam drp_pkg::drp_addr_t REG_CLKOUT0_2 = 7'h09;
  localparam drp_pkg::drp_addr_t REG_CLKFB_1   = 7'h14;
  localparam drp_pkg::drp_addr_t REG_CLKFB_2   = 7'h15;

  localparam drp_pkg::drp_data_t MASK_CNT_1 = 16'hF000;  // keep bits 15:12
  localparam drp_pkg::drp_data_t MASK_CNT_2 = 16'hFF00;  // keep bits 15:8

  // output 0 runs at k+3 high and low, feedback at 8+2k high and low
  function automatic cfg_seq_t table_seq(freq_idx_t k);
    logic [5:0] out_cnt;
    logic [5:0] fb_cnt;
    cfg_seq_t   seq;
    out_cnt = 6'(k) + 6'd3;
    fb_cnt  = 6'd8 + {3'b000, k, 1'b0};
    seq[0]  = '{addr: REG_CLKOUT0_1, mask: MASK_CNT_1, data: {4'h0, out_cnt, out_cnt}};
    seq[1]  = '{addr: REG_CLKOUT0_2, mask: MASK_CNT_2, data: 16'h0000};
    seq[2]  = '{addr: REG_CLKFB_1, mask: MASK_CNT_1, data: {4'h0, fb_cnt, fb_cnt}};
    seq[3]  = '{addr: REG_CLKFB_2, mask: MASK_CNT_2, data: 16'h0000};
    return seq;
  endfunction

endpackage

/* src/freq_select.sv */
`timescale 1ns/1ps

module freq_select (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req,
  input  logic [1:0]               req_sel,
  input  logic                     busy,
  output logic                     sel_valid,
  output clock_cfg_pkg::freq_idx_t sel_idx,
  output logic                     rejected
);

  logic pending;  // accepted, but the sequencer has not raised busy yet
  logic accept;

  assign accept = req && !busy && !pending && (req_sel != clock_cfg_pkg::FREQ_RESERVED);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_valid <= 1'b0;
      rejected  <= 1'b0;
      pending   <= 1'b0;
    end else begin
      sel_valid <= accept;
      rejected  <= req && !accept;  // busy, in flight, or reserved index
      if (accept) begin
        pending <= 1'b1;
      end else if (busy) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sel_idx <= req_sel;
    end
  end

endmodule

/* src/clock_rom.sv */
`timescale 1ns/1ps

module clock_rom (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sel_valid,
  input  clock_cfg_pkg::freq_idx_t sel_idx,
  output logic                     update,
  output clock_cfg_pkg::cfg_seq_t  seq
);

  // ==========================================================================
  // frequency table with one step sequence per legal index
  // ==========================================================================

  localparam clock_cfg_pkg::cfg_seq_t FREQ_TABLE [4] = '{
    clock_cfg_pkg::table_seq(2'd0),
    clock_cfg_pkg::table_seq(2'd1),
    clock_cfg_pkg::table_seq(2'd2),
    clock_cfg_pkg::table_seq(2'd3)   // the reserved index is never selected
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      update <= 1'b0;
    end else begin
      update <= sel_valid;
    end
  end

  // seq is held until the next accepted request so the sequencer
  // can walk it step by step
  always_ff @(posedge clk) begin
    if (sel_valid) begin
      seq <= FREQ_TABLE[sel_idx];
    end
  end

endmodule

/* src/clock_drp.sv */
`timescale 1ns/1ps

module clock_drp #(
  parameter int LOCK_TIMEOUT = 64
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    update,
  input  clock_cfg_pkg::cfg_seq_t seq,
  output drp_pkg::drp_req_t       drp_req,
  input  drp_pkg::drp_rsp_t       drp_rsp,
  output logic                    mmcm_rst,
  input  logic                    locked,
  output logic                    busy,
  output logic                    fault
);

  localparam int SW = $clog2(clock_cfg_pkg::STEPS);
  localparam int TW = $clog2(LOCK_TIMEOUT + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_REQ,
    S_RD_WAIT,
    S_WR_REQ,
    S_WR_WAIT,
    S_NEXT,
    S_LOCK
  } state_t;

  state_t             state;
  logic [SW-1:0]      step;
  logic [TW-1:0]      lock_timer;
  drp_pkg::drp_data_t rd_data;   // register value from the read half
  drp_pkg::drp_step_t cur;

  assign cur = seq[step];

  // ==========================================================================
  // DRP access with en only in the two request states
  // ==========================================================================

  always_comb begin
    drp_req.en   = (state == S_RD_REQ) || (state == S_WR_REQ);
    drp_req.we   = (state == S_WR_REQ);
    drp_req.addr = cur.addr;
    drp_req.di   = (rd_data & cur.mask) | (cur.data & ~cur.mask);
  end

  always_ff @(posedge clk) begin
    if (state == S_RD_WAIT && drp_rsp.rdy) begin
      rd_data <= drp_rsp.dout;
    end
  end

  // ==========================================================================
  // sequencer
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      step       <= '0;
      lock_timer <= '0;
      mmcm_rst   <= 1'b1;  // synthesizer held until the first configuration
      busy       <= 1'b0;
      fault      <= 1'b0;
    end else begin
      fault <= 1'b0;
      case (state)
        S_IDLE: begin
          if (update) begin
            state    <= S_RD_REQ;
            step     <= '0;
            mmcm_rst <= 1'b1;
            busy     <= 1'b1;
          end
        end
        S_RD_REQ:  state <= S_RD_WAIT;
        S_RD_WAIT: if (drp_rsp.rdy) state <= S_WR_REQ;
        S_WR_REQ:  state <= S_WR_WAIT;
        S_WR_WAIT: if (drp_rsp.rdy) state <= S_NEXT;
        S_NEXT: begin
          if (step == SW'(clock_cfg_pkg::STEPS - 1)) begin
            mmcm_rst   <= 1'b0;  // all registers are written so it may lock now
            lock_timer <= '0;
            state      <= S_LOCK;
          end else begin
            step  <= step + 1'b1;
            state <= S_RD_REQ;
          end
        end
        S_LOCK: begin
          if (locked) begin
            busy  <= 1'b0;
            state <= S_IDLE;
          end else if (lock_timer == TW'(LOCK_TIMEOUT - 1)) begin
            fault <= 1'b1;
            busy  <= 1'b0;
            state <= S_IDLE;
          end else begin
            lock_timer <= lock_timer + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* src/mmcm_drp_model.sv */
`timescale 1ns/1ps

module mmcm_drp_model #(
  parameter int DRDY_LATENCY = 3,
  parameter int LOCK_CYCLES  = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  drp_pkg::drp_req_t            drp_req,
  output drp_pkg::drp_rsp_t            drp_rsp,
  input  logic                         mmcm_rst,
  output logic                         locked,
  output clock_cfg_pkg::mmcm_setting_t setting
);

  localparam int CW = $clog2(LOCK_CYCLES + 1);

  drp_pkg::drp_data_t      regs [128];
  drp_pkg::drp_data_t      rd_q;
  logic [DRDY_LATENCY-1:0] rdy_pipe;  // one bit per cycle of access latency
  logic [CW-1:0]           lock_cnt;
  logic                    locked_q;

  // ==========================================================================
  // register file that is accessed when en is seen and answers later
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 128; i++) begin
        regs[i] <= 16'hA000 + 16'(i);  // power-up value
      end
    end else if (drp_req.en && drp_req.we) begin
      regs[drp_req.addr] <= drp_req.di;
    end
  end

  always_ff @(posedge clk) begin
    if (drp_req.en) begin
      rd_q <= regs[drp_req.addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_pipe <= '0;
    end else begin
      rdy_pipe <= (rdy_pipe << 1) | DRDY_LATENCY'(drp_req.en);
    end
  end

  assign drp_rsp.rdy  = rdy_pipe[DRDY_LATENCY-1];
  assign drp_rsp.dout = rd_q;

  // lock comes a fixed time after reset is released
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_cnt <= '0;
      locked_q <= 1'b0;
    end else if (mmcm_rst) begin
      lock_cnt <= '0;
      locked_q <= 1'b0;
    end else if (!locked_q) begin
      lock_cnt <= lock_cnt + 1'b1;
      locked_q <= (lock_cnt == CW'(LOCK_CYCLES - 1));
    end
  end

  assign locked = locked_q && !mmcm_rst;  // lost at once when reset rises

  assign setting.out0_high = regs[7'h08][11:6];
  assign setting.out0_low  = regs[7'h08][5:0];
  assign setting.fb_high   = regs[7'h14][11:6];
  assign setting.fb_low    = regs[7'h14][5:0];

endmodule

/* src/clock_reconfig.sv */
`timescale 1ns/1ps

module clock_reconfig #(
  parameter int DRDY_LATENCY = 3,
  parameter int LOCK_CYCLES  = 16,
  parameter int LOCK_TIMEOUT = 64
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req,
  input  logic [1:0]                   req_sel,
  output logic                         busy,
  output logic                         locked,
  output logic                         rejected,
  output logic                         fault,
  output clock_cfg_pkg::mmcm_setting_t setting
);

  logic                     sel_valid;
  clock_cfg_pkg::freq_idx_t sel_idx;
  logic                     update;
  clock_cfg_pkg::cfg_seq_t  seq;
  drp_pkg::drp_req_t        drp_req;
  drp_pkg::drp_rsp_t        drp_rsp;
  logic                     mmcm_rst;

  // ==========================================================================
  // request check, table lookup, DRP sequencer, synthesizer
  // ==========================================================================

  freq_select i_freq_select (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_sel   (req_sel),
    .busy      (busy),
    .sel_valid (sel_valid),
    .sel_idx   (sel_idx),
    .rejected  (rejected)
  );

  clock_rom i_clock_rom (
    .clk       (clk),
    .rst_n     (rst_n),
    .sel_valid (sel_valid),
    .sel_idx   (sel_idx),
    .update    (update),
    .seq       (seq)
  );

  clock_drp #(
    .LOCK_TIMEOUT (LOCK_TIMEOUT)
  ) i_clock_drp (
    .clk      (clk),
    .rst_n    (rst_n),
    .update   (update),
    .seq      (seq),
    .drp_req  (drp_req),
    .drp_rsp  (drp_rsp),
    .mmcm_rst (mmcm_rst),
    .locked   (locked),
    .busy     (busy),
    .fault    (fault)
  );

  mmcm_drp_model #(
    .DRDY_LATENCY (DRDY_LATENCY),
    .LOCK_CYCLES  (LOCK_CYCLES)
  ) i_mmcm (
    .clk      (clk),
    .rst_n    (rst_n),
    .drp_req  (drp_req),
    .drp_rsp  (drp_rsp),
    .mmcm_rst (mmcm_rst),
    .locked   (locked),
    .setting  (setting)
  );

endmodule

/* sim/clock_reconfig_properties.sv */
`timescale 1ns/1ps

module clock_reconfig_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              update,
  input logic              busy,
  input drp_pkg::drp_req_t drp_req,
  input drp_pkg::drp_rsp_t drp_rsp,
  input logic              mmcm_rst
);

  logic       outstanding;     // access issued and rdy not yet seen
  logic       wr_outstanding;
  logic       cfg_active;      // from update until the last write is answered
  logic [2:0] wr_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding    <= 1'b0;
      wr_outstanding <= 1'b0;
      cfg_active     <= 1'b0;
      wr_done        <= '0;
    end else begin
      if (drp_req.en) begin
        outstanding    <= 1'b1;
        wr_outstanding <= drp_req.we;
      end else if (drp_rsp.rdy) begin
        outstanding    <= 1'b0;
        wr_outstanding <= 1'b0;
      end
      if (update && !busy) begin
        cfg_active <= 1'b1;
        wr_done    <= '0;
      end else if (cfg_active && drp_rsp.rdy && wr_outstanding) begin
        if (wr_done == 3'(clock_cfg_pkg::STEPS - 1)) begin
          cfg_active <= 1'b0;
        end
        wr_done <= wr_done + 3'd1;
      end
    end
  end

  // ==========================================================================
  // DRP handshake
  // ==========================================================================

  en_single: assert property (@(posedge clk) disable iff (!rst_n)
    drp_req.en |=> !drp_req.en)
    else $error("DRP en held for more than one cycle");

  en_not_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding |-> !drp_req.en)
    else $error("DRP en issued while an access is outstanding");

  rst_during_cfg: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_active |-> mmcm_rst)
    else $error("synthesizer reset released before the last write completed");

endmodule

/* sim/tb_clock_reconfig.sv */
`timescale 1ns/1ps

module tb_clock_reconfig;

  localparam int REQ_LIMIT      = 40;
  localparam int CYCLES_PER_REQ = 200;  // one request finishes far inside this
  localparam int MAX_CYCLES     = REQ_LIMIT * CYCLES_PER_REQ;

  logic                         clk;
  logic                         rst_n;
  logic                         req;
  logic [1:0]                   req_sel;
  logic                         busy;
  logic                         locked;
  logic                         rejected;
  logic                         fault;
  clock_cfg_pkg::mmcm_setting_t setting;

  logic [15:0] lfsr;
  logic [15:0] model_regs [128];  // reference copy of the synthesizer registers
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          rejects = 0;
  int          busy_rises = 0;
  int          faults = 0;
  logic        busy_q = 1'b0;

  clock_reconfig i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_sel  (req_sel),
    .busy     (busy),
    .locked   (locked),
    .rejected (rejected),
    .fault    (fault),
    .setting  (setting)
  );

  bind clock_drp clock_reconfig_properties i_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .update   (update),
    .busy     (busy),
    .drp_req  (drp_req),
    .drp_rsp  (drp_rsp),
    .mmcm_rst (mmcm_rst)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // pulse counters and the run limit
  always @(posedge clk) begin
    cycles++;
    if (rst_n && rejected) rejects++;
    if (rst_n && fault) faults++;
    if (rst_n && busy && !busy_q) busy_rises++;
    busy_q = busy;
    if (cycles == MAX_CYCLES) begin
      $display("timeout after %0d cycles, a request never finished", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ==========================================================================
  // stimulus and reference model
  // ==========================================================================

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic pick_legal_index(output logic [1:0] k);
    logic [15:0] r;
    take_bits(2, r);
    while (r[1:0] == 2'd3) take_bits(2, r);
    k = r[1:0];
  endtask

  task automatic write_model_reg(input logic [6:0] addr, input logic [15:0] keep,
                                 input logic [15:0] data);
    model_regs[addr] = (model_regs[addr] & keep) | (data & ~keep);
  endtask

  // output 0 counts k+3, feedback counts 8+2k, second registers cleared in 7:0
  task automatic apply_table_rule(input logic [1:0] k);
    logic [15:0] out_cnt;
    logic [15:0] fb_cnt;
    out_cnt = 16'(k) + 16'd3;
    fb_cnt  = 16'd8 + 16'(k) * 16'd2;
    write_model_reg(7'h08, 16'hF000, (out_cnt << 6) | out_cnt);
    write_model_reg(7'h09, 16'hFF00, 16'h0000);
    write_model_reg(7'h14, 16'hF000, (fb_cnt << 6) | fb_cnt);
    write_model_reg(7'h15, 16'hFF00, 16'h0000);
  endtask

  function automatic logic [23:0] expected_setting();
    return {model_regs[7'h08][11:0], model_regs[7'h14][11:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_regs();
    logic [6:0] addrs [4];
    addrs = '{7'h08, 7'h09, 7'h14, 7'h15};
    foreach (addrs[i]) begin
      check_value($sformatf("reg 0x%02h", addrs[i]), i_dut.i_mmcm.regs[addrs[i]],
                  model_regs[addrs[i]]);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s, %0d errors", name, (errors == test_errors) ? "ok" : "mismatch",
             errors - test_errors);
    test_errors = errors;
  endtask

  task automatic send_req(input logic [1:0] sel);
    @(posedge clk);
    req     <= 1'b1;
    req_sel <= sel;
    @(posedge clk);
    req     <= 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (busy !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy !== level) begin
      errors++;
      $display("busy did not reach %0d within %0d cycles", level, limit);
    end
  endtask

  task automatic run_request(input logic [1:0] k);
    int rej0;
    rej0 = rejects;
    send_req(k);
    apply_table_rule(k);
    wait_busy(1'b1, 10);
    wait_busy(1'b0, CYCLES_PER_REQ);
    check_value("locked", locked, 1);
    check_value("rejected pulses", rejects - rej0, 0);
    check_value("setting", setting, expected_setting());
  endtask

  task automatic run_reserved();
    int rej0;
    int rise0;
    rej0  = rejects;
    rise0 = busy_rises;
    send_req(2'd3);
    repeat (8) @(negedge clk);
    check_value("rejected pulses", rejects - rej0, 1);
    check_value("busy rises", busy_rises - rise0, 0);
  endtask

  initial begin
    logic [1:0]  k;
    logic [1:0]  busy_sel;
    logic [15:0] r;
    int          rej0;
    rst_n   = 1'b0;
    req     = 1'b0;
    req_sel = 2'd0;
    lfsr    = 16'd43;
    for (int i = 0; i < 128; i++) model_regs[i] = 16'hA000 + 16'(i);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    check_value("busy", busy, 0);
    check_value("locked", locked, 0);
    check_value("rejected", rejected, 0);
    check_value("fault", fault, 0);
    check_value("setting", setting, expected_setting());
    end_test("reset");

    pick_legal_index(k);
    run_request(k);
    end_test("legal_request");

    repeat (4) begin
      pick_legal_index(k);
      run_request(k);
      check_regs();
    end
    end_test("kept_bits");

    run_reserved();
    end_test("reserved_index");

    // three more legal strobes while the first request is still being applied
    rej0 = rejects;
    pick_legal_index(k);
    send_req(k);
    apply_table_rule(k);
    wait_busy(1'b1, 10);
    repeat (3) begin
      pick_legal_index(busy_sel);
      send_req(busy_sel);
    end
    repeat (2) @(negedge clk);
    check_value("rejected pulses", rejects - rej0, 3);
    wait_busy(1'b0, CYCLES_PER_REQ);
    check_value("setting", setting, expected_setting());
    end_test("request_while_busy");

    repeat (REQ_LIMIT) begin
      take_bits(2, r);
      if (r[1:0] == 2'd3) run_reserved();
      else run_request(r[1:0]);
    end
    check_regs();
    check_value("fault pulses", faults, 0);
    end_test("random_requests");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/drp_pkg.sv
src/clock_cfg_pkg.sv
src/freq_select.sv
src/clock_rom.sv
src/clock_drp.sv
src/mmcm_drp_model.sv
src/clock_reconfig.sv
sim/clock_reconfig_properties.sv
sim/tb_clock_reconfig.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_clock_reconfig -o sim_clock_reconfig

./obj_dir/sim_clock_reconfig | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
